// File: Makefile
# Verilator build and run of the decode slice testbench

TOP := tb_decode_slice

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wall -f build.f --top-module $(TOP)

# The run passes only if the pass line shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir

// File: build.f
design/core_pkg.sv
design/decode_bus_if.sv
design/register_file.sv
design/instr_decoder.sv
design/decode_exec_reg.sv
design/execute_unit.sv
design/decode_slice_top.sv
testbench/tb_decode_slice.sv

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  // Data path and instruction word width
  localparam int XLEN = 32;

  // Register index width and architectural register count
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Major opcodes of the supported RV32I subset
  // Register form, ADD SUB AND OR XOR
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  // Immediate form, ADDI ANDI ORI XORI
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // Conditional branches, only BEQ is decoded
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Funct3 field values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;

  // Funct7 values of the register form
  // Base encoding used by ADD AND OR XOR
  localparam logic [6:0] F7_BASE = 7'b0000000;
  // Alternate encoding that turns ADD into SUB
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ALU operation selected by the decoder
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // ADDI x0,x0,0 placed in the pipeline on a flush
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage : core_pkg

`default_nettype wire

// File: design/decode_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction, no handshake, valid is a level per cycle
interface decode_bus_if;
  import core_pkg::*;

  // Slot holds a real instruction this cycle
  logic valid;
  // Raw word and its PC
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] pc;
  // Destination index, zero when nothing is written
  logic [REG_ADDR_W-1:0] rd;
  // ALU operands, op_b already muxed between rs2 and immediate
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  // I-type or B-type immediate
  logic [XLEN-1:0] imm;
  // Control bits
  alu_op_e alu_op;
  logic reg_write;
  logic branch;

  // Producer side
  modport src (
    output valid, instr, pc, rd, op_a, op_b, imm, alu_op, reg_write, branch
  );

  // Consumer side
  modport dst (
    input valid, instr, pc, rd, op_a, op_b, imm, alu_op, reg_write, branch
  );

endinterface : decode_bus_if

`default_nettype wire

// File: design/decode_exec_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_exec_reg (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic stall,
  input  wire logic flush,
  decode_bus_if.dst in_bus,
  decode_bus_if.src out_bus
);
  import core_pkg::*;

  // Control bits of the slot, cleared by reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_bus.valid     <= 1'b0;
      out_bus.reg_write <= 1'b0;
      out_bus.branch    <= 1'b0;
    end
    else if (flush)
    begin
      // Flush wins over stall and over a valid input
      out_bus.valid     <= 1'b0;
      out_bus.reg_write <= 1'b0;
      out_bus.branch    <= 1'b0;
    end
    else if (stall)
    begin
      // Held slot must not execute a second time
      out_bus.valid <= 1'b0;
    end
    else
    begin
      out_bus.valid     <= in_bus.valid;
      out_bus.reg_write <= in_bus.reg_write;
      out_bus.branch    <= in_bus.branch;
    end
  end

  // Payload of the slot
  always_ff @(posedge clk)
  begin
    if (flush)
    begin
      // Turn the slot into ADDI x0,x0,0
      out_bus.instr  <= NOP_INSTR;
      out_bus.pc     <= in_bus.pc;
      out_bus.rd     <= '0;
      out_bus.op_a   <= '0;
      out_bus.op_b   <= '0;
      out_bus.imm    <= '0;
      out_bus.alu_op <= ALU_ADD;
    end
    else if (!stall)
    begin
      out_bus.instr  <= in_bus.instr;
      out_bus.pc     <= in_bus.pc;
      out_bus.rd     <= in_bus.rd;
      out_bus.op_a   <= in_bus.op_a;
      out_bus.op_b   <= in_bus.op_b;
      out_bus.imm    <= in_bus.imm;
      out_bus.alu_op <= in_bus.alu_op;
    end
    // Stall keeps everything as it is
  end

endmodule : decode_exec_reg

`default_nettype wire

// File: design/decode_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_slice_top (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            instr_valid,
  input  wire logic [core_pkg::XLEN-1:0]       instr,
  input  wire logic [core_pkg::XLEN-1:0]       pc,
  input  wire logic                            stall,
  input  wire logic                            flush,
  output logic                                 wb_valid,
  output logic      [core_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic      [core_pkg::XLEN-1:0]       wb_data,
  output logic                                 branch_taken,
  output logic      [core_pkg::XLEN-1:0]       branch_target
);
  import core_pkg::*;

  // Source register indices and read data
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  // Writeback from execute into the register file
  logic                  wr_en;
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [XLEN-1:0]       wr_data;

  // Decoder output and pipeline register output
  decode_bus_if dec_bus ();
  decode_bus_if ex_bus ();

  register_file u_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rs1),
    .rd_addr_b (rs2),
    .rd_data_a (rs1_data),
    .rd_data_b (rs2_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  instr_decoder u_instr_decoder (
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .bus         (dec_bus.src)
  );

  // Stall and flush come straight from the upstream source
  decode_exec_reg u_decode_exec_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .flush   (flush),
    .in_bus  (dec_bus.dst),
    .out_bus (ex_bus.src)
  );

  execute_unit u_execute_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (ex_bus.dst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

endmodule : decode_slice_top

`default_nettype wire

// File: design/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  decode_bus_if.dst                       bus,
  output logic                            wr_en,
  output logic [core_pkg::REG_ADDR_W-1:0] wr_addr,
  output logic [core_pkg::XLEN-1:0]       wr_data,
  output logic                            wb_valid,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [core_pkg::XLEN-1:0]       wb_data,
  output logic                            branch_taken,
  output logic [core_pkg::XLEN-1:0]       branch_target
);
  import core_pkg::*;

  // ALU output for the slot in the pipeline register
  logic [XLEN-1:0] alu_result;

  // BEQ outcome and target
  logic            take_branch;
  logic [XLEN-1:0] target;

  always_comb
  begin
    case (bus.alu_op)
      ALU_ADD: alu_result = bus.op_a + bus.op_b;
      ALU_SUB: alu_result = bus.op_a - bus.op_b;
      ALU_AND: alu_result = bus.op_a & bus.op_b;
      ALU_OR:  alu_result = bus.op_a | bus.op_b;
      ALU_XOR: alu_result = bus.op_a ^ bus.op_b;
      default: alu_result = '0;
    endcase
  end

  // Equality compare on the two register operands
  assign take_branch = bus.valid && bus.branch && (bus.op_a == bus.op_b);
  // PC relative target
  assign target = bus.pc + bus.imm;

  // Writeback lands at the end of this cycle
  // x0 never produces a write
  assign wr_en   = bus.valid && bus.reg_write && (bus.rd != '0);
  assign wr_addr = bus.rd;
  assign wr_data = alu_result;

  // Event strobes, one cycle each
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_valid     <= 1'b0;
      branch_taken <= 1'b0;
    end
    else
    begin
      wb_valid     <= wr_en;
      branch_taken <= take_branch;
    end
  end

  // Event payload, kept until the next event of the same kind
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      wb_rd   <= wr_addr;
      wb_data <= wr_data;
    end
    if (take_branch)
    begin
      branch_target <= target;
    end
  end

endmodule : execute_unit

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  wire logic                            instr_valid,
  input  wire logic [core_pkg::XLEN-1:0]       instr,
  input  wire logic [core_pkg::XLEN-1:0]       pc,
  output logic      [core_pkg::REG_ADDR_W-1:0] rs1,
  output logic      [core_pkg::REG_ADDR_W-1:0] rs2,
  input  wire logic [core_pkg::XLEN-1:0]       rs1_data,
  input  wire logic [core_pkg::XLEN-1:0]       rs2_data,
  decode_bus_if.src                            bus
);
  import core_pkg::*;

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Sign-extended immediates
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;

  // Class of the word, at most one is set
  logic is_op;
  logic is_op_imm;
  logic is_beq;

  // Funct3 selects one of the four ALU functions
  logic f3_ok;
  alu_op_e alu_op;
  logic reg_write;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Source indices go straight to the register file
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // I-type, imm[11:0] in the upper bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  // B-type, scrambled bits and an implied zero LSB
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  // Map funct3 to the ALU function
  always_comb
  begin
    alu_op = ALU_ADD;
    f3_ok  = 1'b1;
    case (funct3)
      F3_ADD_SUB: alu_op = ALU_ADD;
      F3_XOR:     alu_op = ALU_XOR;
      F3_OR:      alu_op = ALU_OR;
      F3_AND:     alu_op = ALU_AND;
      default:    f3_ok  = 1'b0;
    endcase
    // SUB only exists in the register form
    if ((opcode == OPC_OP) && (funct3 == F3_ADD_SUB) && (funct7 == F7_SUB))
      alu_op = ALU_SUB;
  end

  // Register form needs the base funct7, or F7_SUB with funct3 000
  assign is_op = (opcode == OPC_OP) && f3_ok &&
                 ((funct7 == F7_BASE) || ((funct7 == F7_SUB) && (funct3 == F3_ADD_SUB)));
  assign is_op_imm = (opcode == OPC_OP_IMM) && f3_ok;
  assign is_beq    = (opcode == OPC_BRANCH) && (funct3 == F3_BEQ);

  // Anything else decodes to a slot with no effect
  assign reg_write = is_op || is_op_imm;

  // Bundle toward the pipeline register
  assign bus.valid     = instr_valid;
  assign bus.instr     = instr;
  assign bus.pc        = pc;
  // BEQ and unsupported words carry no destination
  assign bus.rd        = reg_write ? instr[11:7] : '0;
  assign bus.op_a      = rs1_data;
  // Immediate form takes the immediate, register form and BEQ take rs2
  assign bus.op_b      = is_op_imm ? imm_i : rs2_data;
  assign bus.imm       = is_beq ? imm_b : imm_i;
  assign bus.alu_op    = alu_op;
  assign bus.reg_write = reg_write;
  assign bus.branch    = is_beq;

endmodule : instr_decoder

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] rd_addr_a,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] rd_addr_b,
  output logic      [core_pkg::XLEN-1:0]       rd_data_a,
  output logic      [core_pkg::XLEN-1:0]       rd_data_b,
  input  wire logic                           wr_en,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] wr_addr,
  input  wire logic [core_pkg::XLEN-1:0]       wr_data
);
  import core_pkg::*;

  // Architectural registers, entry 0 is never written
  logic [XLEN-1:0] regs [NUM_REGS];

  // Write is active only for a nonzero destination
  logic wr_active;

  assign wr_active = wr_en && (wr_addr != '0);

  // Synchronous clear of the whole file, then one write per cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_active)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Combinational reads
  // Write data is forwarded so a same-cycle reader sees the new value
  always_comb
  begin
    if (rd_addr_a == '0)
      rd_data_a = '0;
    else if (wr_active && (wr_addr == rd_addr_a))
      rd_data_a = wr_data;
    else
      rd_data_a = regs[rd_addr_a];

    if (rd_addr_b == '0)
      rd_data_b = '0;
    else if (wr_active && (wr_addr == rd_addr_b))
      rd_data_b = wr_data;
    else
      rd_data_b = regs[rd_addr_b];
  end

endmodule : register_file

`default_nettype wire

// File: testbench/tb_decode_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_slice;
  import core_pkg::*;

  localparam logic [31:0] SEED = 32'h91b1;
  localparam int NUM_INSTR = 300;
  localparam int DRAIN_TIMEOUT = 40;
  // Instruction kinds in order of register form, immediate form, BEQ and unsupported
  localparam int K_ADD = 0;
  localparam int K_SUB = 1;
  localparam int K_AND = 2;
  localparam int K_OR = 3;
  localparam int K_XOR = 4;
  localparam int K_ADDI = 5;
  localparam int K_ANDI = 6;
  localparam int K_ORI = 7;
  localparam int K_XORI = 8;
  localparam int K_BEQ = 9;
  localparam int K_BAD = 10;

  logic clk;
  logic rst_n;
  logic instr_valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] pc;
  logic stall;
  logic flush;
  logic wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0] wb_data;
  logic branch_taken;
  logic [XLEN-1:0] branch_target;

  // Model register array
  logic [XLEN-1:0] model_regs [32];
  // Expected events where bit 37 marks a branch, then rd and the data or target
  logic [37:0] exp_q [$];
  int exp_cyc_q [$];
  // Instruction offered upstream right now
  int cur_kind;
  logic [REG_ADDR_W-1:0] cur_rd;
  logic [REG_ADDR_W-1:0] cur_rs1;
  logic [REG_ADDR_W-1:0] cur_rs2;
  logic [XLEN-1:0] cur_imm;
  logic [XLEN-1:0] cur_instr;
  logic [XLEN-1:0] cur_pc;
  logic [XLEN-1:0] next_pc;
  int cycle_count = 0;
  int error_count;
  int check_count;
  int test_count;
  logic [37:0] mon_exp;
  int mon_cyc;

  decode_slice_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .pc            (pc),
    .stall         (stall),
    .flush         (flush),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Counts rising edges to time each event against its acceptance
  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  function automatic logic [2:0] funct3_of(input int kind);
    case (kind)
      K_AND, K_ANDI: return 3'b111;
      K_OR, K_ORI:   return 3'b110;
      K_XOR, K_XORI: return 3'b100;
      default:       return 3'b000;
    endcase
  endfunction

  // Encode one instruction and make it the upstream word
  task automatic set_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] imm);
    logic [12:0] b;
    logic [6:0] f7;
    b = imm[12:0];
    f7 = (kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    cur_kind = kind;
    cur_rd = rd;
    cur_rs1 = rs1;
    cur_rs2 = rs2;
    cur_imm = imm;
    cur_pc = next_pc;
    next_pc = next_pc + 32'd4;
    if (kind <= K_XOR)
      cur_instr = {f7, rs2, rs1, funct3_of(kind), rd, OPC_OP};
    else if (kind <= K_XORI)
      cur_instr = {imm[11:0], rs1, funct3_of(kind), rd, OPC_OP_IMM};
    else if (kind == K_BEQ)
      cur_instr = {b[12], b[10:5], rs2, rs1, 3'b000, b[4:1], b[11], OPC_BRANCH};
    // BNE is a branch the slice does not decode
    else if (imm[0])
      cur_instr = {b[12], b[10:5], rs2, rs1, 3'b001, b[4:1], b[11], OPC_BRANCH};
    else
      cur_instr = {imm[31:7], 7'b0000011};
  endtask

  task automatic pick_instr(input int max_kind);
    logic [31:0] r;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int kind;
    r = $urandom;
    kind = int'($urandom % (max_kind + 1));
    // Only x0 to x7 so that dependencies are frequent
    rs1 = 5'($urandom % 8);
    rs2 = (kind == K_BEQ && r[31]) ? rs1 : 5'($urandom % 8);
    if (kind == K_BEQ)
      set_instr(kind, 5'd0, rs1, rs2, {{19{r[11]}}, r[11:0], 1'b0});
    else if (kind == K_BAD)
      set_instr(kind, 5'd0, rs1, rs2, r);
    else
      set_instr(kind, 5'($urandom % 8), rs1, rs2, {{20{r[11]}}, r[11:0]});
  endtask

  // Applies the accepted word to the model in program order
  task automatic apply_instr(input int event_cycle);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = model_regs[cur_rs1];
    b = (cur_kind >= K_ADDI && cur_kind <= K_XORI) ? cur_imm : model_regs[cur_rs2];
    case (cur_kind)
      K_ADD, K_ADDI: res = a + b;
      K_SUB:         res = a - b;
      K_AND, K_ANDI: res = a & b;
      K_OR, K_ORI:   res = a | b;
      default:       res = a ^ b;
    endcase
    if (cur_kind <= K_XORI && cur_rd != 5'd0)
    begin
      model_regs[cur_rd] = res;
      exp_q.push_back({1'b0, cur_rd, res});
      exp_cyc_q.push_back(event_cycle);
    end
    else if (cur_kind == K_BEQ && a == b)
    begin
      exp_q.push_back({1'b1, 5'd0, cur_pc + cur_imm});
      exp_cyc_q.push_back(event_cycle);
    end
  endtask

  task automatic drive_slot(input bit iv, input bit st, input bit fl);
    @(posedge clk);
    #2;
    instr_valid = iv;
    instr = iv ? cur_instr : NOP_INSTR;
    pc = cur_pc;
    stall = st;
    flush = fl;
  endtask

  task automatic wait_drain(input string name, input int start_errors);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("Timeout in %s: %0d expected events never came out", name, exp_q.size());
      error_count++;
      exp_q.delete();
      exp_cyc_q.delete();
    end
    else
    begin
      // Quiet cycles catch a late duplicate
      repeat (4) @(posedge clk);
    end
    test_count++;
    $display("%s finished with %0d errors", name, error_count - start_errors);
  endtask

  task automatic run_program(input string name, input int max_kind, input int stall_pct,
                             input int flush_pct);
    int issued;
    int start_errors;
    bit have;
    bit iv;
    bit st;
    bit fl;
    issued = 0;
    have = 0;
    start_errors = error_count;
    while (issued < NUM_INSTR)
    begin
      if (!have)
        pick_instr(max_kind);
      have = 1;
      iv = ($urandom % 8) != 0;
      st = ($urandom % 100) < stall_pct;
      fl = ($urandom % 100) < flush_pct;
      drive_slot(iv, st, fl);
      // A flushed word is lost and a stalled one is offered again
      if (iv && (fl || !st))
      begin
        if (!fl)
          apply_instr(cycle_count + 2);
        have = 0;
        issued++;
      end
    end
    drive_slot(1'b0, 1'b0, 1'b0);
    wait_drain(name, start_errors);
  endtask

  // Pops one expectation per event and samples at the falling edge
  always @(negedge clk)
  begin
    if (rst_n && (wb_valid || branch_taken))
    begin
      if (exp_q.size() == 0)
      begin
        $display("Error at %0t: an event came out with no instruction pending", $time);
        error_count++;
      end
      else
      begin
        mon_exp = exp_q.pop_front();
        mon_cyc = exp_cyc_q.pop_front();
        check_value(32'(branch_taken), 32'(mon_exp[37]), "branch event flag");
        check_value(32'(wb_valid), 32'(!mon_exp[37]), "writeback event flag");
        check_value(cycle_count, mon_cyc, "event cycle");
        if (mon_exp[37])
          check_value(branch_target, mon_exp[31:0], "branch_target");
        else
        begin
          check_value(32'(wb_rd), 32'(mon_exp[36:32]), "wb_rd");
          check_value(wb_data, mon_exp[31:0], "wb_data");
        end
      end
    end
  end

  initial
  begin
    int start_errors;
    void'($urandom(SEED));
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = NOP_INSTR;
    pc = '0;
    stall = 1'b0;
    flush = 1'b0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    next_pc = 32'h0000_1000;
    cur_pc = next_pc;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle cycles after reset followed by ADD x1,x0,x0
    start_errors = error_count;
    repeat (6)
    begin
      @(negedge clk);
      check_value(32'(wb_valid), 32'd0, "wb_valid while idle");
      check_value(32'(branch_taken), 32'd0, "branch_taken while idle");
    end
    set_instr(K_ADD, 5'd1, 5'd0, 5'd0, 32'd0);
    drive_slot(1'b1, 1'b0, 1'b0);
    apply_instr(cycle_count + 2);
    drive_slot(1'b0, 1'b0, 1'b0);
    wait_drain("reset_idle", start_errors);

    run_program("alu_random", K_XORI, 0, 0);
    run_program("branch_mix", K_BAD, 0, 0);
    run_program("stall_random", K_BAD, 30, 0);
    run_program("flush_random", K_BAD, 20, 15);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule : tb_decode_slice

`default_nettype wire
